/* common/fetch_pkg.sv */
package fetch_pkg;

  //////////////////////////////////////////////////
  // sizing
  //////////////////////////////////////////////////

  // width of an instruction word and of an address
  localparam int unsigned word_w = 32;

  // number of buffer entries (never below two)
  localparam int unsigned fifo_depth = 2;

  // one bit more than an index so a full buffer can be counted
  localparam int unsigned fifo_cnt_w = $clog2(fifo_depth) + 1;

  // usage at which no new sequential fetch is started
  localparam int unsigned alm_full_th = fifo_depth - 1;

  //////////////////////////////////////////////////
  // controller and core side types
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    idle         = 3'd0,
    wait_gnt     = 3'd1,
    wait_rvalid  = 3'd2,
    wait_aborted = 3'd3,
    wait_fault   = 3'd4
  } fetch_state_e;

  // redirect request from the core
  typedef struct packed {
    logic              valid;
    logic [word_w-1:0] target;
  } branch_t;

  // word handed to the core
  typedef struct packed {
    logic              valid;
    logic [word_w-1:0] instr;
  } fetch_out_t;

endpackage

/* common/ibus_pkg.sv */
package ibus_pkg;

  //////////////////////////////////////////////////
  // instruction memory bus
  //////////////////////////////////////////////////

  // byte address, always word aligned on the bus
  localparam int unsigned addr_w = 32;

  // read data width
  localparam int unsigned data_w = 32;

  // request side, held until gnt
  typedef struct packed {
    logic              req;
    logic [addr_w-1:0] addr;
  } ibus_req_t;

  // response side
  // err comes together with gnt for the request of that cycle
  // a faulting grant is never followed by rvalid
  typedef struct packed {
    logic              gnt;
    logic              err;
    logic              rvalid;
    logic [data_w-1:0] rdata;
  } ibus_rsp_t;

endpackage

/* logic/instr_fifo.sv */
`timescale 1ns/1ps

module instr_fifo #(
  parameter int unsigned depth = fetch_pkg::fifo_depth
) (
  input  logic                               clk,
  input  logic                               rst_n,

  input  logic                               flush_i,
  input  logic                               push_i,
  input  logic                               pop_i,
  input  logic [fetch_pkg::word_w-1:0]       wdata_i,

  output logic [fetch_pkg::word_w-1:0]       rdata_o,
  output logic                               empty_o,
  output logic                               full_o,
  output logic [fetch_pkg::fifo_cnt_w-1:0]   usage_o
);

  // pointer index and entry count widths for this depth
  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth) + 1;

  // storage, payload only
  logic [fetch_pkg::word_w-1:0]  mem_q [depth];

  logic [ptr_w-1:0]              rd_ptr_q;
  logic [ptr_w-1:0]              wr_ptr_q;
  logic [cnt_w-1:0]              cnt_q;

  logic                          do_push;
  logic                          do_pop;

  // wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == cnt_w'(depth));
  assign usage_o = fetch_pkg::fifo_cnt_w'(cnt_q);

  // head of the queue, no fall through
  assign rdata_o = mem_q[rd_ptr_q];

  // flush wins over both sides
  assign do_pop  = pop_i & ~empty_o & ~flush_i;
  // a full buffer still takes a word when the head leaves
  assign do_push = push_i & ~flush_i & (~full_o | do_pop);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // count only moves when one side acts alone
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

/* logic/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                               clk,
  input  logic                               rst_n,

  // core side control
  input  logic                               req_i,
  input  fetch_pkg::branch_t                 branch_i,
  input  logic                               ready_i,

  // instruction memory bus
  output ibus_pkg::ibus_req_t                ibus_req_o,
  input  ibus_pkg::ibus_rsp_t                ibus_rsp_i,

  // buffer control
  output logic                               fifo_push_o,
  output logic                               fifo_pop_o,
  output logic                               fifo_flush_o,
  output logic [fetch_pkg::word_w-1:0]       fifo_wdata_o,
  input  logic [fetch_pkg::word_w-1:0]       fifo_rdata_i,
  input  logic                               fifo_empty_i,
  input  logic [fetch_pkg::fifo_cnt_w-1:0]   fifo_usage_i,

  // core side data and status
  output fetch_pkg::fetch_out_t              fetch_o,
  output logic                               fetch_failed_o,
  output logic                               busy_o
);

  fetch_pkg::fetch_state_e          state_q;
  fetch_pkg::fetch_state_e          state_d;
  fetch_pkg::fetch_state_e          issue_next;

  // last address put on the bus (or pending branch target)
  logic [fetch_pkg::word_w-1:0]     addr_q;
  logic                             addr_upd;

  logic [fetch_pkg::word_w-1:0]     seq_addr;
  logic [fetch_pkg::word_w-1:0]     tgt_addr;

  logic                             fifo_valid;
  logic                             fifo_ready;
  logic                             rsp_live;

  //////////////////////////////////////////////////
  // addresses
  //////////////////////////////////////////////////

  // next word after the last issued one
  assign seq_addr = {addr_q[fetch_pkg::word_w-1:2], 2'b00} + fetch_pkg::word_w'(4);

  // branch targets are forced onto a word boundary
  assign tgt_addr = {branch_i.target[fetch_pkg::word_w-1:2], 2'b00};

  //////////////////////////////////////////////////
  // buffer status
  //////////////////////////////////////////////////

  assign fifo_valid = ~fifo_empty_i;

  // below the threshold the one outstanding word always finds a free slot
  assign fifo_ready = (fifo_usage_i < fetch_pkg::fifo_cnt_w'(fetch_pkg::alm_full_th));

  // returned word that belongs to the current stream
  // a branch in the same cycle makes it stale
  assign rsp_live = ibus_rsp_i.rvalid & (state_q == fetch_pkg::wait_rvalid)
                  & ~branch_i.valid;

  // where a request raised in this cycle leads
  always_comb begin
    if (!ibus_rsp_i.gnt) begin
      issue_next = fetch_pkg::wait_gnt;
    end else if (ibus_rsp_i.err) begin
      // access fault, no rvalid will follow
      issue_next = fetch_pkg::wait_fault;
    end else begin
      issue_next = fetch_pkg::wait_rvalid;
    end
  end

  //////////////////////////////////////////////////
  // fetch FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    ibus_req_o.req  = 1'b0;
    ibus_req_o.addr = addr_q;
    addr_upd        = 1'b0;

    unique case (state_q)
      // nothing outstanding
      fetch_pkg::idle: begin
        ibus_req_o.addr = branch_i.valid ? tgt_addr : seq_addr;
        if (branch_i.valid || (req_i && fifo_ready)) begin
          ibus_req_o.req = 1'b1;
          addr_upd       = 1'b1;
          state_d        = issue_next;
        end
      end

      // request raised, address held until the grant
      fetch_pkg::wait_gnt: begin
        ibus_req_o.req = 1'b1;
        // a branch may still swap the address
        if (branch_i.valid) begin
          ibus_req_o.addr = tgt_addr;
          addr_upd        = 1'b1;
        end
        state_d = issue_next;
      end

      // granted, word still on its way
      fetch_pkg::wait_rvalid: begin
        if (ibus_rsp_i.rvalid) begin
          if (branch_i.valid) begin
            // old word dropped, go straight to the target
            ibus_req_o.req  = 1'b1;
            ibus_req_o.addr = tgt_addr;
            addr_upd        = 1'b1;
            state_d         = issue_next;
          end else if (req_i && fifo_ready) begin
            // back to back sequential fetch
            ibus_req_o.req  = 1'b1;
            ibus_req_o.addr = seq_addr;
            addr_upd        = 1'b1;
            state_d         = issue_next;
          end else begin
            state_d = fetch_pkg::idle;
          end
        end else if (branch_i.valid) begin
          // remember the target, the stale word must come back first
          ibus_req_o.addr = tgt_addr;
          addr_upd        = 1'b1;
          state_d         = fetch_pkg::wait_aborted;
        end
      end

      // stale word outstanding, addr_q holds the target
      fetch_pkg::wait_aborted: begin
        if (branch_i.valid) begin
          ibus_req_o.addr = tgt_addr;
          addr_upd        = 1'b1;
        end
        if (ibus_rsp_i.rvalid) begin
          ibus_req_o.req = 1'b1;
          state_d        = issue_next;
        end
      end

      // parked after an access fault until the core branches
      fetch_pkg::wait_fault: begin
        if (branch_i.valid) begin
          ibus_req_o.req  = 1'b1;
          ibus_req_o.addr = tgt_addr;
          addr_upd        = 1'b1;
          state_d         = issue_next;
        end
      end

      default: begin
        state_d = fetch_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= fetch_pkg::idle;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      if (addr_upd) begin
        addr_q <= ibus_req_o.addr;
      end
    end
  end

  //////////////////////////////////////////////////
  // buffer control and output select
  //////////////////////////////////////////////////

  // every branch empties the buffer
  assign fifo_flush_o = branch_i.valid;

  // park the word unless the core takes it on the bypass path
  assign fifo_push_o  = rsp_live & (fifo_valid | ~ready_i);
  assign fifo_wdata_o = ibus_rsp_i.rdata;

  // head leaves on a handshake
  assign fifo_pop_o   = fifo_valid & ready_i & ~branch_i.valid;

  always_comb begin
    if (fifo_valid) begin
      // oldest buffered word first
      fetch_o.valid = ~branch_i.valid;
      fetch_o.instr = fifo_rdata_i;
    end else begin
      // empty buffer, word goes through in its rvalid cycle
      fetch_o.valid = rsp_live;
      fetch_o.instr = ibus_rsp_i.rdata;
    end
  end

  //////////////////////////////////////////////////
  // status
  //////////////////////////////////////////////////

  // fault shows only once the good words ahead of it are gone
  assign fetch_failed_o = (state_q == fetch_pkg::wait_fault) & ~fetch_o.valid
                        & ~branch_i.valid;

  assign busy_o = (state_q != fetch_pkg::idle) | ibus_req_o.req;

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // from the core
  input  logic                   req_i,
  input  fetch_pkg::branch_t     branch_i,
  input  logic                   ready_i,

  // to the core
  output fetch_pkg::fetch_out_t  fetch_o,
  output logic                   fetch_failed_o,
  output logic                   busy_o,

  // instruction memory
  output ibus_pkg::ibus_req_t    ibus_req_o,
  input  ibus_pkg::ibus_rsp_t    ibus_rsp_i
);

  //////////////////////////////////////////////////
  // controller to buffer
  //////////////////////////////////////////////////

  logic                              fifo_push;
  logic                              fifo_pop;
  logic                              fifo_flush;
  logic [fetch_pkg::word_w-1:0]      fifo_wdata;
  logic [fetch_pkg::word_w-1:0]      fifo_rdata;
  logic                              fifo_empty;
  logic [fetch_pkg::fifo_cnt_w-1:0]  fifo_usage;

  fetch_ctrl fetch_ctrl_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .branch_i       (branch_i),
    .ready_i        (ready_i),
    .ibus_req_o     (ibus_req_o),
    .ibus_rsp_i     (ibus_rsp_i),
    .fifo_push_o    (fifo_push),
    .fifo_pop_o     (fifo_pop),
    .fifo_flush_o   (fifo_flush),
    .fifo_wdata_o   (fifo_wdata),
    .fifo_rdata_i   (fifo_rdata),
    .fifo_empty_i   (fifo_empty),
    .fifo_usage_i   (fifo_usage),
    .fetch_o        (fetch_o),
    .fetch_failed_o (fetch_failed_o),
    .busy_o         (busy_o)
  );

  // controller works from the usage count, full stays open
  instr_fifo #(
    .depth (fetch_pkg::fifo_depth)
  ) instr_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (fifo_flush),
    .push_i  (fifo_push),
    .pop_i   (fifo_pop),
    .wdata_i (fifo_wdata),
    .rdata_o (fifo_rdata),
    .empty_o (fifo_empty),
    .full_o  (),
    .usage_o (fifo_usage)
  );

endmodule

/* bench/imem_model.sv */
`timescale 1ns/1ps

module imem_model #(
  parameter logic [31:0] fault_lo = 32'h0000_8000,
  parameter logic [31:0] fault_hi = 32'h0000_8100
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  ibus_pkg::ibus_req_t  ibus_req_i,
  output ibus_pkg::ibus_rsp_t  ibus_rsp_o,
  // delays for the next grant (0..3) and response (1..3)
  input  logic [1:0]           gnt_dly_i,
  input  logic [1:0]           rsp_dly_i,
  // lookup into the program image held by the testbench
  output logic [31:0]          rd_addr_o,
  input  logic [31:0]          rd_data_i
);

  logic [1:0] wait_q;
  logic [1:0] gnt_dly_q;
  logic [1:0] rsp_cnt_q;
  logic       pend_q;
  logic       gnt;
  logic       fault;

  // grant once the request has waited long enough
  assign gnt   = ibus_req_i.req & (wait_q >= gnt_dly_q);
  assign fault = (ibus_req_i.addr >= fault_lo) & (ibus_req_i.addr < fault_hi);

  assign ibus_rsp_o.gnt    = gnt;
  assign ibus_rsp_o.err    = gnt & fault;
  assign ibus_rsp_o.rvalid = pend_q & (rsp_cnt_q == 2'd1);
  assign ibus_rsp_o.rdata  = rd_data_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q    <= '0;
      gnt_dly_q <= '0;
      rsp_cnt_q <= '0;
      pend_q    <= 1'b0;
      rd_addr_o <= '0;
    end else begin
      // response countdown
      if (ibus_rsp_o.rvalid) begin
        pend_q <= 1'b0;
      end else if (pend_q) begin
        rsp_cnt_q <= rsp_cnt_q - 2'd1;
      end
      // a new grant may land in the rvalid cycle of the old one
      if (gnt) begin
        wait_q    <= '0;
        gnt_dly_q <= gnt_dly_i;
        // faulting grant, no data follows
        if (!fault) begin
          pend_q    <= 1'b1;
          rsp_cnt_q <= rsp_dly_i;
          rd_addr_o <= ibus_req_i.addr;
        end
      end else if (ibus_req_i.req) begin
        wait_q <= wait_q + 2'd1;
      end
    end
  end

endmodule

/* bench/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

  localparam logic [31:0] fault_lo     = 32'h0000_8000;
  localparam logic [31:0] fault_hi     = 32'h0000_8100;
  localparam logic [31:0] lfsr_seed    = 32'h79f1_aa84;
  localparam int unsigned redirect_cnt = 40;
  // ready modes for one cycle
  localparam int rdy_low  = 0;
  localparam int rdy_high = 1;
  localparam int rdy_rand = 2;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  logic                  ready;
  fetch_pkg::branch_t    branch;
  fetch_pkg::fetch_out_t fetch;
  fetch_pkg::fetch_out_t exp_word;
  logic                  fetch_failed;
  logic                  busy;
  ibus_pkg::ibus_req_t   ibus_req;
  ibus_pkg::ibus_rsp_t   ibus_rsp;
  logic [1:0]            gnt_dly;
  logic [1:0]            rsp_dly;
  logic [31:0]           mem_addr;
  logic [31:0]           mem_rdata;

  logic [31:0]           lfsr;
  logic [31:0]           exp_pc;
  int unsigned           accepted;
  logic                  failed_seen;
  logic                  idle_seen;
  logic                  expect_idle;

  fetch_top fetch_top_i (
    .clk(clk), .rst_n(rst_n), .req_i(req), .branch_i(branch), .ready_i(ready),
    .fetch_o(fetch), .fetch_failed_o(fetch_failed), .busy_o(busy),
    .ibus_req_o(ibus_req), .ibus_rsp_i(ibus_rsp)
  );

  imem_model #(.fault_lo(fault_lo), .fault_hi(fault_hi)) imem_model_i (
    .clk(clk), .rst_n(rst_n), .ibus_req_i(ibus_req), .ibus_rsp_o(ibus_rsp),
    .gnt_dly_i(gnt_dly), .rsp_dly_i(rsp_dly), .rd_addr_o(mem_addr), .rd_data_i(mem_rdata)
  );

  //////////////////////////////////////////////////
  // reference model and random source
  //////////////////////////////////////////////////

  // program image, address mixed with its rotation and a constant
  function automatic logic [31:0] instr_at(input logic [31:0] addr);
    return (addr ^ {addr[20:0], addr[31:21]}) + 32'h9e37_79b9;
  endfunction

  function automatic logic in_fault_window(input logic [31:0] addr);
    return (addr >= fault_lo) && (addr < fault_hi);
  endfunction

  assign mem_rdata = instr_at(mem_addr);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] draw_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_fetch(input fetch_pkg::fetch_out_t got, input fetch_pkg::fetch_out_t exp);
    if (got !== exp) begin
      $display("Error at %0t ns: fetch_o got valid=%b instr=%h, expected valid=%b instr=%h",
               $time, got.valid, got.instr, exp.valid, exp.instr);
      stop_with_failure();
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s got %b, expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // sample in the middle of the cycle, inputs settled since the rising edge
  always @(negedge clk) begin
    if (expect_idle) begin
      compare_flag("fetch_o.valid", fetch.valid, 1'b0);
      compare_flag("ibus_req_o.req", ibus_req.req, 1'b0);
      compare_flag("busy_o", busy, 1'b0);
    end
    idle_seen = ~busy & ~ibus_req.req & ~fetch.valid;
    if (branch.valid) begin
      // nothing from the old stream may be taken
      compare_flag("fetch handshake in branch cycle", fetch.valid & ready, 1'b0);
      exp_pc      = branch.target;
      failed_seen = 1'b0;
    end else begin
      if (fetch.valid && ready) begin
        exp_word.valid = 1'b1;
        exp_word.instr = instr_at(exp_pc);
        compare_fetch(fetch, exp_word);
        exp_pc   = exp_pc + 32'd4;
        accepted = accepted + 1;
      end
      if (fetch_failed) begin
        // only the word at the expected pc may be the faulting one
        compare_flag("fetch_failed_o", fetch_failed, in_fault_window(exp_pc));
        compare_flag("fetch_o.valid with fault", fetch.valid, 1'b0);
        failed_seen = 1'b1;
      end else if (failed_seen) begin
        compare_flag("fetch_failed_o", fetch_failed, 1'b1);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // inputs change 1 ns after the rising edge, branch lasts one cycle
  task automatic tick(input int mode);
    logic [31:0] r;
    @(posedge clk);
    #1;
    branch  = '0;
    r       = draw_bits(2);
    gnt_dly = r[1:0];
    r       = draw_bits(2);
    rsp_dly = (r[1:0] == 2'd0) ? 2'd1 : r[1:0];
    r       = draw_bits(2);
    case (mode)
      rdy_low:  ready = 1'b0;
      rdy_high: ready = 1'b1;
      default:  ready = (r[1:0] != 2'd0);
    endcase
  endtask

  task automatic issue_branch(input logic [31:0] target);
    branch.valid  = 1'b1;
    branch.target = target;
  endtask

  task automatic wait_words(input int unsigned n, input int mode);
    int unsigned goal;
    int unsigned cycles;
    goal   = accepted + n;
    cycles = 0;
    while (accepted < goal) begin
      if (cycles == n * 40 + 20) begin
        $display("timeout at %0t ns: %0d of %0d words arrived", $time, n - (goal - accepted), n);
        stop_with_failure();
      end
      tick(mode);
      cycles++;
    end
  endtask

  task automatic wait_failed();
    int unsigned cycles;
    cycles = 0;
    do begin
      if (cycles == 80) begin
        $display("timeout at %0t ns: fetch_failed_o never rose in the fault window", $time);
        stop_with_failure();
      end
      tick(rdy_rand);
      cycles++;
    end while (!failed_seen);
  endtask

  task automatic wait_idle();
    int unsigned cycles;
    cycles = 0;
    do begin
      if (cycles == 80) begin
        $display("timeout at %0t ns: fetcher did not go idle with req_i low", $time);
        stop_with_failure();
      end
      tick(rdy_high);
      cycles++;
    end while (!idle_seen);
  endtask

  initial begin
    int unsigned i;
    logic [31:0] r;
    logic [31:0] k;
    rst_n       = 1'b0;
    req         = 1'b0;
    ready       = 1'b0;
    branch      = '0;
    gnt_dly     = 2'd0;
    rsp_dly     = 2'd1;
    lfsr        = lfsr_seed;
    exp_pc      = '0;
    accepted    = 0;
    failed_seen = 1'b0;
    idle_seen   = 1'b0;
    exp_word    = '0;
    expect_idle = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) tick(rdy_high);

    // plain sequential stream
    tick(rdy_high);
    expect_idle = 1'b0;
    req         = 1'b1;
    issue_branch(32'h0000_0100);
    wait_words(24, rdy_high);

    // long stalls from the core
    for (i = 0; i < 8; i++) begin
      r = draw_bits(3);
      repeat (4 + r) tick(rdy_low);
      wait_words(6, rdy_rand);
    end

    // branches at random times, some with a full buffer
    for (i = 0; i < redirect_cnt; i++) begin
      r = draw_bits(3);
      k = draw_bits(1);
      repeat (r) tick((k != 0) ? rdy_low : rdy_rand);
      tick(rdy_rand);
      issue_branch(draw_bits(12) << 2);
      wait_words(1 + draw_bits(2), rdy_rand);
    end

    // straight into the fault window, then running into it
    tick(rdy_rand);
    issue_branch(32'h0000_8010);
    wait_failed();
    repeat (10) tick(rdy_rand);
    tick(rdy_rand);
    issue_branch(32'h0000_7ff0);
    wait_words(4, rdy_rand);
    wait_failed();
    repeat (6) tick(rdy_rand);
    tick(rdy_rand);
    issue_branch(32'h0000_0200);
    wait_words(12, rdy_rand);

    // fetching switched off
    tick(rdy_high);
    req = 1'b0;
    wait_idle();
    expect_idle = 1'b1;
    repeat (8) tick(rdy_rand);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* project.f */
common/fetch_pkg.sv
common/ibus_pkg.sv
logic/instr_fifo.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
bench/imem_model.sv
bench/fetch_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = fetch_tb
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
